/* test/decoder_vectors.txt */
// Columns: 66-bit input block, expected data, expected ctrl, idle flag, error flag (hex, hex, hex, bin, bin).
// Blocks hold the sync header in bits 1..0 and are listed in arrival order.
0000000000000007a 0707070707070707 ff 1 0
1dd995510cc8845e2 77665544332211fb 01 0 0
0048d159e26af37bd 0123456789abcdef 00 0 0
20000000000000005 8000000000000001 00 0 0
1dd995510cc88461e 07070707070707fd ff 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc884666 070707070707fd11 fe 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc8846aa 0707070707fd2211 fc 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc8846d2 07070707fd332211 f8 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc884732 070707fd44332211 f0 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc88474a 0707fd5544332211 e0 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc884786 07fd665544332211 c0 0 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc8847fe fd77665544332211 80 0 0
0000000000000007a 0707070707070707 ff 1 0
00000000f0000007a 07070707fe070707 ff 0 0
0048d159e26af37bd fefefefefefefefe ff 0 1
0000000000000007a 0707070707070707 ff 1 0
1dd995510cc8845e2 77665544332211fb 01 0 0
1dd995510cc8845e2 fefefefefefefefe ff 0 1
0048d159e26af37bd 0123456789abcdef 00 0 0
1dd995510cc8846d2 fefefefefefefefe ff 0 1
20000000000000005 8000000000000001 00 0 0
0000000000000007a fefefefefefefefe ff 0 1
0048d159e26af37bc fefefefefefefefe ff 0 1
0000000000000007a 0707070707070707 ff 1 0
000000000000000b6 fefefefefefefefe ff 0 1
1dd995510cc8845e2 fefefefefefefefe ff 0 1
0000000000000007b fefefefefefefefe ff 0 1
1dd995510cc88461e 07070707070707fd ff 0 0
0000000000000007a 0707070707070707 ff 1 0

/* list.f */
source/pcs_rx_pkg.sv
source/decoder_comparator.sv
source/decoder_fsm_interface.sv
source/decoder_fsm.sv
source/decoder.sv
test/decoder_assertions.sv
test/decoder_tb.sv

/* run.sh */
#!/bin/sh
# Builds the decoder testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module decoder_tb -o decoder_sim

./obj_dir/decoder_sim

/* test/decoder_tb.sv */
`timescale 1ns/1ps

module decoder_tb;

    localparam int NB_ERROR_COUNTER = 32;
    localparam int CLOCK_PERIOD     = 40;
    localparam int RESET_CYCLES     = 5;
    localparam int PIPE_DEPTH       = 3;
    localparam int FREEZE_AT        = 12;
    localparam int FREEZE_CYCLES    = 6;
    localparam logic [31:0] SEED    = 32'h659c_bd15;
    localparam logic [pcs_rx_pkg::NB_DATA_CODED-1:0] IDLE_BLOCK = 66'h0_0000_0000_0000_007a;

    // Expected result of one block at the decoder output.
    typedef struct packed {
        pcs_rx_pkg::xgmii_word_t word;
        logic                    idle;
        logic                    err;
    } expect_t;

    localparam expect_t RESET_EXPECT = '{word: pcs_rx_pkg::IDLE_WORD, idle: 1'b1, err: 1'b0};

    logic                                 i_clock;
    logic                                 i_arst_n;
    logic                                 i_enable;
    logic                                 i_valid;
    logic [pcs_rx_pkg::NB_DATA_CODED-1:0] i_data;
    logic [pcs_rx_pkg::NB_DATA-1:0]       o_data;
    logic [pcs_rx_pkg::NB_CTRL-1:0]       o_ctrl;
    logic                                 o_fsm_control;
    logic [NB_ERROR_COUNTER-1:0]          o_rf_error_counter;

    logic [pcs_rx_pkg::NB_DATA_CODED-1:0] blocks[$];
    expect_t                              vectors[$];
    expect_t                              pending[$];
    pcs_rx_pkg::xgmii_word_t              out_word;
    pcs_rx_pkg::xgmii_word_t              last_word;
    logic                                 last_flag;
    logic [NB_ERROR_COUNTER-1:0]          last_count;
    logic [NB_ERROR_COUNTER-1:0]          model_count = '0;
    logic                                 adv_pending = 1'b0;
    logic                                 vectors_loaded = 1'b0;

    decoder #(
        .NB_ERROR_COUNTER (NB_ERROR_COUNTER)
    ) decoder_inst (
        .i_clock            (i_clock),
        .i_arst_n           (i_arst_n),
        .i_enable           (i_enable),
        .i_valid            (i_valid),
        .i_data             (i_data),
        .o_data             (o_data),
        .o_ctrl             (o_ctrl),
        .o_fsm_control      (o_fsm_control),
        .o_rf_error_counter (o_rf_error_counter)
    );

    assign out_word = {o_data, o_ctrl};

    initial begin
        i_clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    // **************************************************
    // Reporting and compare tasks.
    // **************************************************
    task automatic stop_with_failure(input string why);
        $display("Test failures found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input pcs_rx_pkg::xgmii_word_t got,
                              input pcs_rx_pkg::xgmii_word_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("Output word mismatch.");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            stop_with_failure("Flag mismatch.");
        end
    endtask

    task automatic check_count(input string name, input logic [NB_ERROR_COUNTER-1:0] got,
                               input logic [NB_ERROR_COUNTER-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_with_failure("Error count mismatch.");
        end
    endtask

    // Compares one advance's outputs against the oldest queued expectation.
    task automatic check_output();
        expect_t exp;
        if (pending.size() == 0) begin
            stop_with_failure("An advance happened with no expected result queued.");
        end else begin
            exp = pending.pop_front();
            if (exp.err) begin
                model_count++;
            end
            check_word("o_data/o_ctrl", out_word, exp.word);
            check_flag("o_fsm_control", o_fsm_control, exp.idle);
            check_count("o_rf_error_counter", o_rf_error_counter, model_count);
        end
    endtask

    // **************************************************
    // Stimulus.
    // **************************************************
    task automatic load_vectors();
        int                                   fd;
        int                                   n;
        string                                line;
        logic [pcs_rx_pkg::NB_DATA_CODED-1:0] block;
        logic [pcs_rx_pkg::NB_DATA-1:0]       data;
        logic [pcs_rx_pkg::NB_CTRL-1:0]       ctrl;
        logic                                 idle;
        logic                                 err;
        fd = $fopen("test/decoder_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open test/decoder_vectors.txt.");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n != 0 && $sscanf(line, "%h %h %h %b %b", block, data, ctrl, idle, err) == 5)
                begin
                    blocks.push_back(block);
                    vectors.push_back('{word: {data, ctrl}, idle: idle, err: err});
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [pcs_rx_pkg::NB_DATA_CODED-1:0] random_block();
        logic [95:0] bits;
        bits = {$urandom, $urandom, $urandom};
        return bits[pcs_rx_pkg::NB_DATA_CODED-1:0];
    endfunction

    task automatic drive_cycle(input logic [pcs_rx_pkg::NB_DATA_CODED-1:0] block,
                               input logic valid, input logic enable);
        @(posedge i_clock);
        i_data   <= block;
        i_valid  <= valid;
        i_enable <= enable;
    endtask

    // Random gaps carry junk data, which must never be taken in.
    task automatic offer_block(input logic [pcs_rx_pkg::NB_DATA_CODED-1:0] block,
                               input expect_t entry, input logic tracked);
        while ($urandom_range(3, 0) == 0) begin
            drive_cycle(random_block(), 1'b0, 1'b1);
        end
        drive_cycle(block, 1'b1, 1'b1);
        if (tracked) begin
            pending.push_back(entry);
        end
    endtask

    // Output monitor. Advances are checked, all other cycles must hold.
    always @(negedge i_clock) begin
        if (i_arst_n) begin
            if (adv_pending) begin
                check_output();
            end else begin
                check_word("o_data/o_ctrl", out_word, last_word);
                check_flag("o_fsm_control", o_fsm_control, last_flag);
                check_count("o_rf_error_counter", o_rf_error_counter, last_count);
            end
        end
        last_word   = out_word;
        last_flag   = o_fsm_control;
        last_count  = o_rf_error_counter;
        adv_pending = i_arst_n && i_valid && i_enable;
    end

    initial begin
        int limit;
        wait (vectors_loaded);
        limit = CLOCK_PERIOD * (2 * vectors.size() + 100);
        #(limit);
        stop_with_failure("Watchdog expired before all vectors were checked.");
    end

    initial begin
        i_arst_n = 1'b0;
        i_enable = 1'b1;
        i_valid  = 1'b0;
        i_data   = IDLE_BLOCK;
        void'($urandom(SEED));
        load_vectors();
        vectors_loaded = 1'b1;
        // The first three advances flush the reset contents of the pipeline.
        repeat (PIPE_DEPTH) pending.push_back(RESET_EXPECT);
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_arst_n <= 1'b1;
        @(negedge i_clock);
        check_word("o_data/o_ctrl", out_word, pcs_rx_pkg::IDLE_WORD);
        check_flag("o_fsm_control", o_fsm_control, 1'b0);
        check_count("o_rf_error_counter", o_rf_error_counter, '0);
        foreach (blocks[i]) begin
            if (i == FREEZE_AT) begin
                repeat (FREEZE_CYCLES) drive_cycle(blocks[i], 1'b1, 1'b0);
            end
            offer_block(blocks[i], vectors[i], 1'b1);
        end
        repeat (PIPE_DEPTH) offer_block(IDLE_BLOCK, RESET_EXPECT, 1'b0);
        drive_cycle(IDLE_BLOCK, 1'b0, 1'b1);
        repeat (2) @(negedge i_clock);
        if (pending.size() != 0) begin
            stop_with_failure("Some expected results never reached the output.");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* test/decoder_assertions.sv */
`timescale 1ns/1ps

module decoder_assertions #(
    parameter int NB_ERROR_COUNTER = 32
) (
    input logic                           i_clock,
    input logic                           i_arst_n,
    input logic                           i_enable,
    input logic                           i_valid,
    input logic [pcs_rx_pkg::NB_DATA-1:0] i_out_data,
    input logic [pcs_rx_pkg::NB_CTRL-1:0] i_out_ctrl,
    input logic                           i_fsm_control,
    input logic [NB_ERROR_COUNTER-1:0]    i_error_counter
);

    logic advance;

    assign advance = i_enable & i_valid;

    // The error count only ever goes up.
    counter_up: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_error_counter >= $past(i_error_counter))
        else $error("Error counter decreased.");

    outputs_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !advance |=> $stable({i_out_data, i_out_ctrl, i_fsm_control, i_error_counter}))
        else $error("Outputs changed without an advance.");

    // An idle word is all control characters.
    idle_is_ctrl: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_fsm_control |-> (i_out_ctrl == '1))
        else $error("Idle flag set on a word with data lanes.");

    idle_low_in_reset: assert property (@(posedge i_clock) !i_arst_n |-> !i_fsm_control)
        else $error("Idle flag high during reset.");

endmodule

bind decoder decoder_assertions #(
    .NB_ERROR_COUNTER (NB_ERROR_COUNTER)
) u_decoder_assertions (
    .i_clock         (i_clock),
    .i_arst_n        (i_arst_n),
    .i_enable        (i_enable),
    .i_valid         (i_valid),
    .i_out_data      (o_data),
    .i_out_ctrl      (o_ctrl),
    .i_fsm_control   (o_fsm_control),
    .i_error_counter (o_rf_error_counter)
);

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder #(
    parameter int NB_ERROR_COUNTER = 32
) (
    input  logic                                 i_clock,
    input  logic                                 i_arst_n,
    input  logic                                 i_enable,
    input  logic                                 i_valid,
    input  logic [pcs_rx_pkg::NB_DATA_CODED-1:0] i_data,
    output logic [pcs_rx_pkg::NB_DATA-1:0]       o_data,
    output logic [pcs_rx_pkg::NB_CTRL-1:0]       o_ctrl,
    output logic                                 o_fsm_control,
    output logic [NB_ERROR_COUNTER-1:0]          o_rf_error_counter
);

    // **************************************************
    // Stage connections.
    // **************************************************
    pcs_rx_pkg::xgmii_word_t comparator_word;
    pcs_rx_pkg::block_type_e comparator_type;
    pcs_rx_pkg::block_type_e fsm_type;
    pcs_rx_pkg::block_type_e fsm_type_next;
    pcs_rx_pkg::xgmii_word_t fsm_word;

    decoder_comparator u_decoder_comparator (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_enable   (i_enable),
        .i_valid    (i_valid),
        .i_rx_coded (i_data),
        .o_rx_word  (comparator_word),
        .o_rx_type  (comparator_type)
    );

    decoder_fsm_interface u_decoder_fsm_interface (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_enable      (i_enable),
        .i_valid       (i_valid),
        .i_r_type      (comparator_type),
        .o_r_type      (fsm_type),
        .o_r_type_next (fsm_type_next)
    );

    decoder_fsm #(
        .NB_ERROR_COUNTER (NB_ERROR_COUNTER)
    ) u_decoder_fsm (
        .i_clock            (i_clock),
        .i_arst_n           (i_arst_n),
        .i_enable           (i_enable),
        .i_valid            (i_valid),
        .i_r_type           (fsm_type),
        .i_r_type_next      (fsm_type_next),
        .i_rx_word          (comparator_word),
        .o_rx_raw_word      (fsm_word),
        .o_fsm_control      (o_fsm_control),
        .o_rf_error_counter (o_rf_error_counter)
    );

    // XGMII word split onto the data and control ports.
    assign o_data = fsm_word.data;
    assign o_ctrl = fsm_word.ctrl;

endmodule

/* source/decoder_fsm.sv */
`timescale 1ns/1ps

module decoder_fsm #(
    parameter int NB_ERROR_COUNTER = 32
) (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  logic                        i_enable,
    input  logic                        i_valid,
    input  pcs_rx_pkg::block_type_e     i_r_type,
    input  pcs_rx_pkg::block_type_e     i_r_type_next,
    input  pcs_rx_pkg::xgmii_word_t     i_rx_word,
    output pcs_rx_pkg::xgmii_word_t     o_rx_raw_word,
    output logic                        o_fsm_control,
    output logic [NB_ERROR_COUNTER-1:0] o_rf_error_counter
);

    logic                    advance;
    pcs_rx_pkg::rx_state_e   state;
    pcs_rx_pkg::rx_state_e   state_next;
    pcs_rx_pkg::xgmii_word_t word_next;
    pcs_rx_pkg::xgmii_word_t word_cur;
    logic                    next_ok;
    logic                    word_is_idle;
    logic                    counter_full;

    assign advance = i_enable & i_valid;

    // **************************************************
    // Word delay line.
    // **************************************************

    // Word_next lines up with the look-ahead type, word_cur with the current type.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            word_next <= pcs_rx_pkg::IDLE_WORD;
            word_cur  <= pcs_rx_pkg::IDLE_WORD;
        end else if (advance) begin
            word_next <= i_rx_word;
            word_cur  <= word_next;
        end
    end

    // A terminate is only good when a control or start block follows.
    assign next_ok = (i_r_type_next == pcs_rx_pkg::BT_C) ||
                     (i_r_type_next == pcs_rx_pkg::BT_S);

    // **************************************************
    // Receive state machine.
    // **************************************************
    always_comb begin
        state_next = pcs_rx_pkg::RX_E;
        case (state)
            pcs_rx_pkg::RX_INIT,
            pcs_rx_pkg::RX_C,
            pcs_rx_pkg::RX_T: begin
                if (i_r_type == pcs_rx_pkg::BT_C) begin
                    state_next = pcs_rx_pkg::RX_C;
                end else if (i_r_type == pcs_rx_pkg::BT_S) begin
                    state_next = pcs_rx_pkg::RX_D;
                end
            end
            pcs_rx_pkg::RX_D: begin
                if (i_r_type == pcs_rx_pkg::BT_D) begin
                    state_next = pcs_rx_pkg::RX_D;
                end else if (i_r_type == pcs_rx_pkg::BT_T && next_ok) begin
                    state_next = pcs_rx_pkg::RX_T;
                end
            end
            default: begin
                // RX_E leaves only on a block that can stand on its own.
                if (i_r_type == pcs_rx_pkg::BT_C) begin
                    state_next = pcs_rx_pkg::RX_C;
                end else if (i_r_type == pcs_rx_pkg::BT_D) begin
                    state_next = pcs_rx_pkg::RX_D;
                end else if (i_r_type == pcs_rx_pkg::BT_T && next_ok) begin
                    state_next = pcs_rx_pkg::RX_T;
                end
            end
        endcase
    end

    assign word_is_idle = (word_cur == pcs_rx_pkg::IDLE_WORD);
    assign counter_full = (o_rf_error_counter == {NB_ERROR_COUNTER{1'b1}});

    // Output stage and error count.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state              <= pcs_rx_pkg::RX_INIT;
            o_rx_raw_word      <= pcs_rx_pkg::IDLE_WORD;
            o_fsm_control      <= 1'b0;
            o_rf_error_counter <= '0;
        end else if (advance) begin
            state         <= state_next;
            o_fsm_control <= (state_next == pcs_rx_pkg::RX_C) && word_is_idle;
            if (state_next == pcs_rx_pkg::RX_E) begin
                o_rx_raw_word <= pcs_rx_pkg::ERROR_WORD;
                if (!counter_full) begin
                    o_rf_error_counter <= o_rf_error_counter + 1'b1;
                end
            end else begin
                o_rx_raw_word <= word_cur;
            end
        end
    end

endmodule

/* source/decoder_fsm_interface.sv */
`timescale 1ns/1ps

module decoder_fsm_interface (
    input  logic                    i_clock,
    input  logic                    i_arst_n,
    input  logic                    i_enable,
    input  logic                    i_valid,
    input  pcs_rx_pkg::block_type_e i_r_type,
    output pcs_rx_pkg::block_type_e o_r_type,
    output pcs_rx_pkg::block_type_e o_r_type_next
);

    logic advance;

    assign advance = i_enable & i_valid;

    // **************************************************
    // Two-entry type history.
    // **************************************************

    // The look-ahead entry lets the FSM see the block after a terminate.
    // Gaps in i_valid hold both entries, so the pair stays consecutive.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_r_type      <= pcs_rx_pkg::BT_C;
            o_r_type_next <= pcs_rx_pkg::BT_C;
        end else if (advance) begin
            o_r_type      <= o_r_type_next;
            o_r_type_next <= i_r_type;
        end
    end

endmodule

/* source/decoder_comparator.sv */
`timescale 1ns/1ps

module decoder_comparator (
    input  logic                                   i_clock,
    input  logic                                   i_arst_n,
    input  logic                                   i_enable,
    input  logic                                   i_valid,
    input  logic [pcs_rx_pkg::NB_DATA_CODED-1:0]   i_rx_coded,
    output pcs_rx_pkg::xgmii_word_t                o_rx_word,
    output pcs_rx_pkg::block_type_e                o_rx_type
);

    logic                                   advance;
    logic [1:0]                             sync;
    logic [pcs_rx_pkg::NB_TYPE_FIELD-1:0]   type_field;
    logic [55:0]                            payload;
    logic                                   is_term;
    logic [2:0]                             term_len;
    pcs_rx_pkg::xgmii_word_t                dec_word;
    pcs_rx_pkg::block_type_e                dec_type;

    // Maps one 7-bit control code onto its XGMII character.
    function automatic logic [7:0] cc_to_xgmii(input logic [pcs_rx_pkg::NB_CODE-1:0] code);
        logic [7:0] ch;
        case (code)
            pcs_rx_pkg::CC_IDLE:  ch = pcs_rx_pkg::XG_IDLE;
            default:              ch = pcs_rx_pkg::XG_ERROR;
        endcase
        return ch;
    endfunction

    assign advance    = i_enable & i_valid;
    assign sync       = i_rx_coded[1:0];
    assign type_field = i_rx_coded[9:2];
    assign payload    = i_rx_coded[65:10];

    // Terminate types and the number of data bytes ahead of the T.
    always_comb begin
        is_term  = 1'b1;
        term_len = 3'd0;
        case (type_field)
            pcs_rx_pkg::BTF_T0: term_len = 3'd0;
            pcs_rx_pkg::BTF_T1: term_len = 3'd1;
            pcs_rx_pkg::BTF_T2: term_len = 3'd2;
            pcs_rx_pkg::BTF_T3: term_len = 3'd3;
            pcs_rx_pkg::BTF_T4: term_len = 3'd4;
            pcs_rx_pkg::BTF_T5: term_len = 3'd5;
            pcs_rx_pkg::BTF_T6: term_len = 3'd6;
            pcs_rx_pkg::BTF_T7: term_len = 3'd7;
            default:            is_term  = 1'b0;
        endcase
    end

    // **************************************************
    // Block decode.
    // **************************************************
    always_comb begin
        dec_word = pcs_rx_pkg::ERROR_WORD;
        dec_type = pcs_rx_pkg::BT_E;
        if (sync == pcs_rx_pkg::SYNC_DATA) begin
            dec_word.data = i_rx_coded[65:2];
            dec_word.ctrl = '0;
            dec_type      = pcs_rx_pkg::BT_D;
        end else if (sync == pcs_rx_pkg::SYNC_CTRL) begin
            if (type_field == pcs_rx_pkg::BTF_C) begin
                // Eight packed 7-bit codes with lane 0 first.
                for (int lane = 0; lane < pcs_rx_pkg::NB_CTRL; lane++) begin
                    dec_word.data[lane*8 +: 8] = cc_to_xgmii(payload[lane*7 +: 7]);
                end
                dec_word.ctrl = '1;
                dec_type      = pcs_rx_pkg::BT_C;
            end else if (type_field == pcs_rx_pkg::BTF_S) begin
                dec_word.data[7:0] = pcs_rx_pkg::XG_START;
                for (int lane = 1; lane < pcs_rx_pkg::NB_CTRL; lane++) begin
                    dec_word.data[lane*8 +: 8] = payload[(lane-1)*8 +: 8];
                end
                dec_word.ctrl = 8'h01;
                dec_type      = pcs_rx_pkg::BT_S;
            end else if (is_term) begin
                for (int lane = 0; lane < pcs_rx_pkg::NB_CTRL; lane++) begin
                    if (lane < term_len) begin
                        dec_word.data[lane*8 +: 8] = payload[lane*8 +: 8];
                        dec_word.ctrl[lane]        = 1'b0;
                    end else if (lane == term_len) begin
                        dec_word.data[lane*8 +: 8] = pcs_rx_pkg::XG_TERM;
                        dec_word.ctrl[lane]        = 1'b1;
                    end else begin
                        dec_word.data[lane*8 +: 8] = pcs_rx_pkg::XG_IDLE;
                        dec_word.ctrl[lane]        = 1'b1;
                    end
                end
                dec_type = pcs_rx_pkg::BT_T;
            end
        end
    end

    // The register stage holds whenever the block is not qualified.
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rx_word <= pcs_rx_pkg::IDLE_WORD;
            o_rx_type <= pcs_rx_pkg::BT_C;
        end else if (advance) begin
            o_rx_word <= dec_word;
            o_rx_type <= dec_type;
        end
    end

endmodule

/* source/pcs_rx_pkg.sv */
package pcs_rx_pkg;

    // **************************************************
    // Widths fixed by the 64b/66b block format.
    // **************************************************
    localparam int NB_DATA_CODED = 66;
    localparam int NB_DATA       = 64;
    localparam int NB_CTRL       = 8;
    localparam int NB_CODE       = 7;
    localparam int NB_TYPE_FIELD = 8;

    // Sync header, bits 1..0 of the block.
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // Block type field, bits 9..2 of a control block.
    localparam logic [NB_TYPE_FIELD-1:0] BTF_C  = 8'h1E;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_S  = 8'h78;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T0 = 8'h87;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T1 = 8'h99;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T2 = 8'hAA;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T3 = 8'hB4;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T4 = 8'hCC;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T5 = 8'hD2;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T6 = 8'hE1;
    localparam logic [NB_TYPE_FIELD-1:0] BTF_T7 = 8'hFF;

    // XGMII control characters.
    localparam logic [7:0] XG_IDLE  = 8'h07;
    localparam logic [7:0] XG_START = 8'hFB;
    localparam logic [7:0] XG_TERM  = 8'hFD;
    localparam logic [7:0] XG_ERROR = 8'hFE;

    // 7-bit control codes inside a control block.
    localparam logic [NB_CODE-1:0] CC_IDLE  = 7'h00;
    localparam logic [NB_CODE-1:0] CC_ERROR = 7'h1E;

    // **************************************************
    // Types.
    // **************************************************
    typedef enum logic [2:0] {
        BT_C,
        BT_S,
        BT_D,
        BT_T,
        BT_E
    } block_type_e;

    typedef enum logic [2:0] {
        RX_INIT,
        RX_C,
        RX_D,
        RX_T,
        RX_E
    } rx_state_e;

    // Lane 0 sits in the low byte of data and in ctrl bit 0.
    typedef struct packed {
        logic [NB_DATA-1:0] data;
        logic [NB_CTRL-1:0] ctrl;
    } xgmii_word_t;

    localparam xgmii_word_t IDLE_WORD  = '{data: {NB_CTRL{XG_IDLE}}, ctrl: {NB_CTRL{1'b1}}};
    localparam xgmii_word_t ERROR_WORD = '{data: {NB_CTRL{XG_ERROR}}, ctrl: {NB_CTRL{1'b1}}};

endpackage
